// ==== build.f ====
+incdir+source
source/pin_map_pkg.sv
source/board_status_pkg.sv
source/i2c_bus_resolve.sv
source/spi_line_drive.sv
source/pin_loopback.sv
source/cheri_fault_latch.sv
source/board_pin_adapter.sv
testbench/board_adapter_properties.sv
testbench/tb_board_pin_adapter.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_board_pin_adapter
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert -Wno-fatal

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard source/*.sv source/*.svh testbench/*.sv)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "ERRORS FOUND" $(LOG); then \
	  echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== testbench/tb_board_pin_adapter.sv ====
// ################################################
// Testbench for the board pin adapter.
// Random pin stimulus against a reference model of the
// routing, loopback and CHERI fault rules.
// ################################################
`timescale 1ns/1ps
`default_nettype none

module tb_board_pin_adapter;

  logic clk_i;
  logic rst_ni;
  pin_map_pkg::out_pins_t         out_to_pins;
  pin_map_pkg::inout_pins_t       inout_to_pins;
  pin_map_pkg::inout_pins_t       inout_to_pins_en;
  pin_map_pkg::in_pins_t          in_from_pins;
  pin_map_pkg::inout_pins_t       inout_from_pins;
  logic [2:0] scl_dev, sda_dev, scl_bus, sda_bus;
  logic flash_sck, flash_cs, flash_copi, flash_cipo;
  logic sd_sck, sd_cs, sd_copi, sd_cipo;
  logic pmod_sck, pmod_cs, pmod_copi, pmod_cipo;
  logic lcd_copi, lcd_copi_en, lcd_dev_cipo, lcd_line;
  logic uart_tx, uart_rx;
  board_status_pkg::cheri_fault_t cheri_fault, cheri_fault_new, cheri_fault_seen;

  // Reference state, updated at each rising edge.
  pin_map_pkg::out_pins_t         prev_out;
  pin_map_pkg::inout_pins_t       prev_inout;
  board_status_pkg::cheri_fault_t new_ref;
  board_status_pkg::cheri_fault_t seen_ref;

  logic [31:0] lfsr;
  string       test_name;
  logic        check_en;
  int          test_errs;
  int          total_errs;
  int          total_checks;
  int          test_count;

  board_pin_adapter u_board_pin_adapter (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .out_to_pins_i (out_to_pins), .inout_to_pins_i (inout_to_pins),
    .inout_to_pins_en_i (inout_to_pins_en),
    .in_from_pins_o (in_from_pins), .inout_from_pins_o (inout_from_pins),
    .scl_dev_i (scl_dev), .sda_dev_i (sda_dev),
    .scl_bus_o (scl_bus), .sda_bus_o (sda_bus),
    .flash_sck_o (flash_sck), .flash_cs_o (flash_cs),
    .flash_copi_o (flash_copi), .flash_cipo_i (flash_cipo),
    .sd_sck_o (sd_sck), .sd_cs_o (sd_cs), .sd_copi_o (sd_copi), .sd_cipo_i (sd_cipo),
    .pmod_sck_o (pmod_sck), .pmod_cs_o (pmod_cs),
    .pmod_copi_o (pmod_copi), .pmod_cipo_i (pmod_cipo),
    .lcd_copi_i (lcd_copi), .lcd_copi_en_i (lcd_copi_en),
    .lcd_dev_cipo_i (lcd_dev_cipo), .lcd_line_o (lcd_line),
    .uart_tx_o (uart_tx), .uart_rx_i (uart_rx),
    .cheri_fault_i (cheri_fault), .cheri_fault_new_o (cheri_fault_new),
    .cheri_fault_seen_o (cheri_fault_seen)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Fibonacci LFSR, taps 32, 22, 2 and 1.
  function automatic logic next_bit();
    lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
    return lfsr[0];
  endfunction

  function automatic logic [31:0] rand_vec(int width);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < width; i++) begin
      v[i] = next_bit();
    end
    return v;
  endfunction

  // Released line reads high.
  function automatic logic idle_drive(logic v, logic en);
    return en ? v : 1'b1;
  endfunction

  // Bus order is RPi ID, RPi secondary, QWIIC1.
  function automatic logic [2:0] ref_scl_bus(pin_map_pkg::inout_pins_t v,
                                             pin_map_pkg::inout_pins_t en);
    return {idle_drive(v[pin_map_pkg::INOUT_PIN_SCL1], en[pin_map_pkg::INOUT_PIN_SCL1]),
            idle_drive(v[pin_map_pkg::INOUT_PIN_RPH_G3_SCL],
                       en[pin_map_pkg::INOUT_PIN_RPH_G3_SCL]),
            idle_drive(v[pin_map_pkg::INOUT_PIN_RPH_G1], en[pin_map_pkg::INOUT_PIN_RPH_G1])};
  endfunction

  function automatic logic [2:0] ref_sda_bus(pin_map_pkg::inout_pins_t v,
                                             pin_map_pkg::inout_pins_t en);
    return {idle_drive(v[pin_map_pkg::INOUT_PIN_SDA1], en[pin_map_pkg::INOUT_PIN_SDA1]),
            idle_drive(v[pin_map_pkg::INOUT_PIN_RPH_G2_SDA],
                       en[pin_map_pkg::INOUT_PIN_RPH_G2_SDA]),
            idle_drive(v[pin_map_pkg::INOUT_PIN_RPH_G0], en[pin_map_pkg::INOUT_PIN_RPH_G0])};
  endfunction

  // Expected input-only pins.
  function automatic pin_map_pkg::in_pins_t ref_in_pins(pin_map_pkg::out_pins_t p_out);
    pin_map_pkg::in_pins_t e;
    e = '0;
    e[pin_map_pkg::IN_PIN_SER0_RX]      = uart_rx;
    e[pin_map_pkg::IN_PIN_APPSPI_D1]    = flash_cipo;
    e[pin_map_pkg::IN_PIN_MICROSD_DAT0] = sd_cipo;
    e[pin_map_pkg::IN_PIN_MB8]          = p_out[pin_map_pkg::OUT_PIN_MB7];
    e[pin_map_pkg::IN_PIN_MB3]          = p_out[pin_map_pkg::OUT_PIN_MB4];
    return e;
  endfunction

  // Expected bidirectional inputs; unmapped pins stay high.
  function automatic pin_map_pkg::inout_pins_t ref_inout_pins(
      pin_map_pkg::out_pins_t p_out, pin_map_pkg::inout_pins_t p_io);
    pin_map_pkg::inout_pins_t e;
    logic [2:0] scl;
    logic [2:0] sda;
    scl = ref_scl_bus(inout_to_pins, inout_to_pins_en) & scl_dev;
    sda = ref_sda_bus(inout_to_pins, inout_to_pins_en) & sda_dev;
    e = '1;
    e[pin_map_pkg::INOUT_PIN_RPH_G1]     = scl[0];
    e[pin_map_pkg::INOUT_PIN_RPH_G0]     = sda[0];
    e[pin_map_pkg::INOUT_PIN_RPH_G3_SCL] = scl[1];
    e[pin_map_pkg::INOUT_PIN_RPH_G2_SDA] = sda[1];
    e[pin_map_pkg::INOUT_PIN_SCL1]       = scl[2];
    e[pin_map_pkg::INOUT_PIN_SDA1]       = sda[2];
    e[pin_map_pkg::INOUT_PIN_PMOD1_3]    = pmod_cipo;
    e[pin_map_pkg::INOUT_PIN_AH_TMPIO9]  = p_io[pin_map_pkg::INOUT_PIN_AH_TMPIO8];
    e[pin_map_pkg::INOUT_PIN_AH_TMPIO0]  = p_io[pin_map_pkg::INOUT_PIN_AH_TMPIO1];
    e[pin_map_pkg::INOUT_PIN_PMOD0_1]    = p_out[pin_map_pkg::OUT_PIN_MB10];
    e[pin_map_pkg::INOUT_PIN_PMOD0_10]   = p_io[pin_map_pkg::INOUT_PIN_PMOD0_8];
    e[pin_map_pkg::INOUT_PIN_PMODC_1]    = p_io[pin_map_pkg::INOUT_PIN_PMODC_1];
    return e;
  endfunction

  task automatic check_in(string what, pin_map_pkg::in_pins_t exp, pin_map_pkg::in_pins_t act);
    total_checks++;
    if (exp !== act) begin
      test_errs++;
      $display("FAILED %s: %s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_inout(string what, pin_map_pkg::inout_pins_t exp,
                             pin_map_pkg::inout_pins_t act);
    total_checks++;
    if (exp !== act) begin
      test_errs++;
      $display("FAILED %s: %s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  // Names each wrong fault bit.
  task automatic check_fault(string what, board_status_pkg::cheri_fault_t exp,
                             board_status_pkg::cheri_fault_t act);
    board_status_pkg::cheri_fault_e f;
    total_checks++;
    for (int b = 0; b < $bits(exp); b++) begin
      if (exp[b] !== act[b]) begin
        f = board_status_pkg::cheri_fault_e'(b);
        test_errs++;
        $display("FAILED %s: %s %s expected %b actual %b",
                 test_name, what, f.name(), exp[b], act[b]);
      end
    end
  endtask

  task automatic check_line(string what, logic exp, logic act);
    total_checks++;
    if (exp !== act) begin
      test_errs++;
      $display("FAILED %s: %s expected %b actual %b", test_name, what, exp, act);
    end
  endtask

  // Reference state follows the inputs seen at each edge.
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      prev_out   = '0;
      prev_inout = '0;
      new_ref    = '0;
      seen_ref   = '0;
    end else begin
      prev_out   = out_to_pins;
      prev_inout = inout_to_pins;
      new_ref    = cheri_fault & ~seen_ref;
      seen_ref   = seen_ref | new_ref;
    end
  end

  // Outputs are compared mid-cycle, away from both edges.
  always @(negedge clk_i) begin
    logic [2:0] scl_exp;
    logic [2:0] sda_exp;
    if (rst_ni && check_en) begin
      scl_exp = ref_scl_bus(inout_to_pins, inout_to_pins_en);
      sda_exp = ref_sda_bus(inout_to_pins, inout_to_pins_en);
      for (int b = 0; b < 3; b++) begin
        check_line($sformatf("scl_bus[%0d]", b), scl_exp[b], scl_bus[b]);
        check_line($sformatf("sda_bus[%0d]", b), sda_exp[b], sda_bus[b]);
      end
      check_in("in_from_pins", ref_in_pins(prev_out), in_from_pins);
      check_inout("inout_from_pins", ref_inout_pins(prev_out, prev_inout), inout_from_pins);
      check_line("flash_sck", out_to_pins[pin_map_pkg::OUT_PIN_APPSPI_CLK], flash_sck);
      check_line("flash_cs", out_to_pins[pin_map_pkg::OUT_PIN_APPSPI_CS], flash_cs);
      check_line("flash_copi", out_to_pins[pin_map_pkg::OUT_PIN_APPSPI_D0], flash_copi);
      check_line("sd_sck", out_to_pins[pin_map_pkg::OUT_PIN_MICROSD_CLK], sd_sck);
      check_line("sd_cs", out_to_pins[pin_map_pkg::OUT_PIN_MICROSD_DAT3], sd_cs);
      check_line("sd_copi", out_to_pins[pin_map_pkg::OUT_PIN_MICROSD_CMD], sd_copi);
      check_line("pmod_cs", idle_drive(inout_to_pins[pin_map_pkg::INOUT_PIN_PMOD1_1],
                 inout_to_pins_en[pin_map_pkg::INOUT_PIN_PMOD1_1]), pmod_cs);
      check_line("pmod_copi", idle_drive(inout_to_pins[pin_map_pkg::INOUT_PIN_PMOD1_2],
                 inout_to_pins_en[pin_map_pkg::INOUT_PIN_PMOD1_2]), pmod_copi);
      check_line("pmod_sck", idle_drive(inout_to_pins[pin_map_pkg::INOUT_PIN_PMOD1_4],
                 inout_to_pins_en[pin_map_pkg::INOUT_PIN_PMOD1_4]), pmod_sck);
      check_line("lcd_line", lcd_copi_en ? lcd_copi : lcd_dev_cipo, lcd_line);
      check_line("uart_tx", out_to_pins[pin_map_pkg::OUT_PIN_SER0_TX], uart_tx);
      check_fault("fault_new", new_ref, cheri_fault_new);
      check_fault("fault_seen", seen_ref, cheri_fault_seen);
    end
  end

  // All pin-side inputs, fresh each call.
  task automatic randomize_pins();
    out_to_pins      = pin_map_pkg::out_pins_t'(rand_vec($bits(out_to_pins)));
    inout_to_pins    = pin_map_pkg::inout_pins_t'(rand_vec($bits(inout_to_pins)));
    inout_to_pins_en = pin_map_pkg::inout_pins_t'(rand_vec($bits(inout_to_pins_en)));
    scl_dev      = 3'(rand_vec(3));
    sda_dev      = 3'(rand_vec(3));
    flash_cipo   = next_bit();
    sd_cipo      = next_bit();
    pmod_cipo    = next_bit();
    lcd_copi     = next_bit();
    lcd_copi_en  = next_bit();
    lcd_dev_cipo = next_bit();
    uart_rx      = next_bit();
  endtask

  task automatic start_test(string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic finish_test();
    test_count++;
    total_errs += test_errs;
    $display("%s: %s, %0d errors", test_name, (test_errs == 0) ? "ok" : "failed", test_errs);
  endtask

  task automatic abort_run(string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $finish;
  endtask

  task automatic random_cycles(int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
      randomize_pins();
    end
  endtask

  initial begin
    #200000;
    abort_run("Simulation ran past its time limit.");
  end

  initial begin
    board_status_pkg::cheri_fault_t held;
    int waited;
    int assert_errs;
    lfsr = 32'h2272487c;
    check_en = 1'b0;
    total_errs = 0;
    total_checks = 0;
    test_count = 0;
    rst_ni = 1'b0;
    cheri_fault = '0;
    randomize_pins();
    // Random sources during reset must not reach the destinations.
    cheri_fault = board_status_pkg::cheri_fault_t'(rand_vec($bits(cheri_fault)));
    repeat (16) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    cheri_fault = '0;
    start_test("reset");
    check_en = 1'b1;
    @(negedge clk_i);
    check_fault("fault_seen after reset", '0, cheri_fault_seen);
    check_line("MB8 after reset", 1'b0, in_from_pins[pin_map_pkg::IN_PIN_MB8]);
    check_line("PMOD0_10 after reset", 1'b0,
               inout_from_pins[pin_map_pkg::INOUT_PIN_PMOD0_10]);
    finish_test();

    start_test("i2c");
    random_cycles(40);
    finish_test();

    // LCD turnaround in both directions, UART checked along with it.
    start_test("spi");
    repeat (20) begin
      @(posedge clk_i);
      #1;
      randomize_pins();
      lcd_copi_en = 1'b1;
    end
    repeat (20) begin
      @(posedge clk_i);
      #1;
      randomize_pins();
      lcd_copi_en = 1'b0;
    end
    finish_test();

    start_test("loopback");
    random_cycles(40);
    finish_test();

    start_test("cheri");
    @(posedge clk_i);
    #1;
    cheri_fault[board_status_pkg::CHERI_FAULT_BOUNDS] = 1'b1;
    waited = 0;
    while (!cheri_fault_seen[board_status_pkg::CHERI_FAULT_BOUNDS] && waited < 8) begin
      @(posedge clk_i);
      #1;
      waited++;
    end
    if (!cheri_fault_seen[board_status_pkg::CHERI_FAULT_BOUNDS]) begin
      test_errs++;
      $display("Timed out waiting for the first fault to be recorded.");
    end else begin
      held = '0;
      for (int c = 0; c < 60; c++) begin
        @(posedge clk_i);
        #1;
        // Some lines latch high for good, the others flicker.
        if (c % 12 == 0) begin
          held[c / 12] = 1'b1;
        end
        cheri_fault = held | (board_status_pkg::cheri_fault_t'(rand_vec(9)) &
                              board_status_pkg::cheri_fault_t'(rand_vec(9)) &
                              board_status_pkg::cheri_fault_t'(rand_vec(9)));
      end
    end
    finish_test();

    check_en = 1'b0;
    assert_errs = u_board_pin_adapter.u_board_adapter_properties.fail_count;
    if (assert_errs != 0) begin
      $display("%0d assertion failures in the bound checker.", assert_errs);
    end
    total_errs += assert_errs;
    $display("tests %0d, checks %0d, errors %0d", test_count, total_checks, total_errs);
    if (total_errs == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/board_adapter_properties.sv ====
// ################################################
// Assertions bound to the board pin adapter.
// Checks the fault record and loopback timing.
// ################################################
`timescale 1ns/1ps
`default_nettype none

module board_adapter_properties (
  input wire                                 clk_i,
  input wire                                 rst_ni,
  input wire board_status_pkg::cheri_fault_t fault_new_i,
  input wire board_status_pkg::cheri_fault_t fault_seen_i,
  input wire pin_map_pkg::loopback_t         loop_src_i,
  input wire pin_map_pkg::loopback_t         loop_dst_i
);

  // Number of failed assertions.
  int fail_count = 0;

  // The record is sticky.
  sticky_record: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    ($past(fault_seen_i) & ~fault_seen_i) == '0
  ) else begin
    fail_count++;
    $error("fault record lost a bit");
  end

  // A new fault is always in the record as well.
  new_in_record: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (fault_new_i & ~fault_seen_i) == '0
  ) else begin
    fail_count++;
    $error("new fault missing from the record");
  end

  // Destinations trail their sources by one clock.
  loop_delay: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $past(rst_ni) |-> loop_dst_i == $past(loop_src_i)
  ) else begin
    fail_count++;
    $error("loopback destination not one cycle behind its source");
  end

endmodule

bind board_pin_adapter board_adapter_properties u_board_adapter_properties (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .fault_new_i  (cheri_fault_new_o),
  .fault_seen_i (cheri_fault_seen_o),
  .loop_src_i   (loop_src),
  .loop_dst_i   (loop_dst)
);

`default_nettype wire

// ==== source/board_pin_adapter.sv ====
// ################################################
// Board pin adapter top level.
// Turns the pinmux outputs into bus and device lines and
// builds the input pin vectors the system reads back.
// ################################################
`timescale 1ns/1ps
`default_nettype none

`include "board_macros.svh"

module board_pin_adapter (
  input  wire                                 clk_i,
  input  wire                                 rst_ni,
  // System pinmux.
  input  wire pin_map_pkg::out_pins_t         out_to_pins_i,
  input  wire pin_map_pkg::inout_pins_t       inout_to_pins_i,
  input  wire pin_map_pkg::inout_pins_t       inout_to_pins_en_i,
  output pin_map_pkg::in_pins_t               in_from_pins_o,
  output pin_map_pkg::inout_pins_t            inout_from_pins_o,
  // I2C buses: RPi ID, RPi secondary, QWIIC1.
  input  wire  [2:0]                          scl_dev_i,
  input  wire  [2:0]                          sda_dev_i,
  output logic [2:0]                          scl_bus_o,
  output logic [2:0]                          sda_bus_o,
  // SPI devices.
  output logic                                flash_sck_o,
  output logic                                flash_cs_o,
  output logic                                flash_copi_o,
  input  wire                                 flash_cipo_i,
  output logic                                sd_sck_o,
  output logic                                sd_cs_o,
  output logic                                sd_copi_o,
  input  wire                                 sd_cipo_i,
  output logic                                pmod_sck_o,
  output logic                                pmod_cs_o,
  output logic                                pmod_copi_o,
  input  wire                                 pmod_cipo_i,
  // LCD, driven by the system outside the pinmux.
  input  wire                                 lcd_copi_i,
  input  wire                                 lcd_copi_en_i,
  input  wire                                 lcd_dev_cipo_i,
  output logic                                lcd_line_o,
  // System UART.
  output logic                                uart_tx_o,
  input  wire                                 uart_rx_i,
  // CHERI faults.
  input  wire board_status_pkg::cheri_fault_t cheri_fault_i,
  output board_status_pkg::cheri_fault_t      cheri_fault_new_o,
  output board_status_pkg::cheri_fault_t      cheri_fault_seen_o
);

  // I2C controller lines; MSB is QWIIC1, LSB the RPi ID bus.
  logic [2:0] scl_o;
  logic [2:0] scl_oe;
  logic [2:0] sda_o;
  logic [2:0] sda_oe;
  logic [2:0] scl_in;
  logic [2:0] sda_in;
  // PMOD1 lines: sck, copi, cs from MSB down.
  logic [2:0] pmod_pins;
  logic [2:0] pmod_en;
  logic       flash_cipo;
  logic       sd_cipo;
  logic       pmod_cipo;
  pin_map_pkg::loopback_t loop_src;
  pin_map_pkg::loopback_t loop_dst;

  assign scl_o  = {inout_to_pins_i[pin_map_pkg::INOUT_PIN_SCL1],
                   inout_to_pins_i[pin_map_pkg::INOUT_PIN_RPH_G3_SCL],
                   inout_to_pins_i[pin_map_pkg::INOUT_PIN_RPH_G1]};
  assign scl_oe = {inout_to_pins_en_i[pin_map_pkg::INOUT_PIN_SCL1],
                   inout_to_pins_en_i[pin_map_pkg::INOUT_PIN_RPH_G3_SCL],
                   inout_to_pins_en_i[pin_map_pkg::INOUT_PIN_RPH_G1]};
  assign sda_o  = {inout_to_pins_i[pin_map_pkg::INOUT_PIN_SDA1],
                   inout_to_pins_i[pin_map_pkg::INOUT_PIN_RPH_G2_SDA],
                   inout_to_pins_i[pin_map_pkg::INOUT_PIN_RPH_G0]};
  assign sda_oe = {inout_to_pins_en_i[pin_map_pkg::INOUT_PIN_SDA1],
                   inout_to_pins_en_i[pin_map_pkg::INOUT_PIN_RPH_G2_SDA],
                   inout_to_pins_en_i[pin_map_pkg::INOUT_PIN_RPH_G0]};

  i2c_bus_resolve u_i2c_bus_resolve (
    .scl_o_i   (scl_o),
    .scl_oe_i  (scl_oe),
    .sda_o_i   (sda_o),
    .sda_oe_i  (sda_oe),
    .scl_dev_i (scl_dev_i),
    .sda_dev_i (sda_dev_i),
    .scl_bus_o (scl_bus_o),
    .sda_bus_o (sda_bus_o),
    .scl_in_o  (scl_in),
    .sda_in_o  (sda_in)
  );

  assign pmod_pins = {inout_to_pins_i[pin_map_pkg::INOUT_PIN_PMOD1_4],
                      inout_to_pins_i[pin_map_pkg::INOUT_PIN_PMOD1_2],
                      inout_to_pins_i[pin_map_pkg::INOUT_PIN_PMOD1_1]};
  assign pmod_en   = {inout_to_pins_en_i[pin_map_pkg::INOUT_PIN_PMOD1_4],
                      inout_to_pins_en_i[pin_map_pkg::INOUT_PIN_PMOD1_2],
                      inout_to_pins_en_i[pin_map_pkg::INOUT_PIN_PMOD1_1]};

  spi_line_drive u_spi_line_drive (
    .out_pins_i     (out_to_pins_i),
    .pmod_pins_i    (pmod_pins),
    .pmod_en_i      (pmod_en),
    .flash_cipo_i   (flash_cipo_i),
    .sd_cipo_i      (sd_cipo_i),
    .pmod_cipo_i    (pmod_cipo_i),
    .lcd_copi_i     (lcd_copi_i),
    .lcd_copi_en_i  (lcd_copi_en_i),
    .lcd_dev_cipo_i (lcd_dev_cipo_i),
    .flash_sck_o    (flash_sck_o),
    .flash_cs_o     (flash_cs_o),
    .flash_copi_o   (flash_copi_o),
    .sd_sck_o       (sd_sck_o),
    .sd_cs_o        (sd_cs_o),
    .sd_copi_o      (sd_copi_o),
    .pmod_sck_o     (pmod_sck_o),
    .pmod_cs_o      (pmod_cs_o),
    .pmod_copi_o    (pmod_copi_o),
    .lcd_line_o     (lcd_line_o),
    .flash_cipo_o   (flash_cipo),
    .sd_cipo_o      (sd_cipo),
    .pmod_cipo_o    (pmod_cipo)
  );

  // Loopback sources, in pair order from the MSB.
  // Arduino 8 and 1, mikroBUS PWM, UART and SPI, PMOD0 8, PMODC 1.
  assign loop_src = {inout_to_pins_i[pin_map_pkg::INOUT_PIN_AH_TMPIO8],
                     inout_to_pins_i[pin_map_pkg::INOUT_PIN_AH_TMPIO1],
                     out_to_pins_i[pin_map_pkg::OUT_PIN_MB10],
                     out_to_pins_i[pin_map_pkg::OUT_PIN_MB7],
                     out_to_pins_i[pin_map_pkg::OUT_PIN_MB4],
                     inout_to_pins_i[pin_map_pkg::INOUT_PIN_PMOD0_8],
                     inout_to_pins_i[pin_map_pkg::INOUT_PIN_PMODC_1]};

  pin_loopback u_pin_loopback (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .src_i  (loop_src),
    .dst_o  (loop_dst)
  );

  cheri_fault_latch u_cheri_fault_latch (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .fault_i      (cheri_fault_i),
    .fault_new_o  (cheri_fault_new_o),
    .fault_seen_o (cheri_fault_seen_o)
  );

  assign uart_tx_o = out_to_pins_i[pin_map_pkg::OUT_PIN_SER0_TX];

  // Every input-only pin has a source.
  always_comb begin
    in_from_pins_o = '0;
    in_from_pins_o[pin_map_pkg::IN_PIN_SER0_RX]      = uart_rx_i;
    in_from_pins_o[pin_map_pkg::IN_PIN_APPSPI_D1]    = flash_cipo;
    in_from_pins_o[pin_map_pkg::IN_PIN_MICROSD_DAT0] = sd_cipo;
    in_from_pins_o[pin_map_pkg::IN_PIN_MB8]          = loop_dst[3];
    in_from_pins_o[pin_map_pkg::IN_PIN_MB3]          = loop_dst[2];
  end

  // Pins without a model read the pull-up level.
  always_comb begin
    inout_from_pins_o = {`INOUT_PIN_NUM{`LINE_IDLE}};
    inout_from_pins_o[pin_map_pkg::INOUT_PIN_RPH_G1]     = scl_in[0];
    inout_from_pins_o[pin_map_pkg::INOUT_PIN_RPH_G0]     = sda_in[0];
    inout_from_pins_o[pin_map_pkg::INOUT_PIN_RPH_G3_SCL] = scl_in[1];
    inout_from_pins_o[pin_map_pkg::INOUT_PIN_RPH_G2_SDA] = sda_in[1];
    inout_from_pins_o[pin_map_pkg::INOUT_PIN_SCL1]       = scl_in[2];
    inout_from_pins_o[pin_map_pkg::INOUT_PIN_SDA1]       = sda_in[2];
    inout_from_pins_o[pin_map_pkg::INOUT_PIN_PMOD1_3]    = pmod_cipo;
    inout_from_pins_o[pin_map_pkg::INOUT_PIN_AH_TMPIO9]  = loop_dst[6];
    inout_from_pins_o[pin_map_pkg::INOUT_PIN_AH_TMPIO0]  = loop_dst[5];
    inout_from_pins_o[pin_map_pkg::INOUT_PIN_PMOD0_1]    = loop_dst[4];
    inout_from_pins_o[pin_map_pkg::INOUT_PIN_PMOD0_10]   = loop_dst[1];
    // PMODC 1 reads itself back, for pin-change interrupts.
    inout_from_pins_o[pin_map_pkg::INOUT_PIN_PMODC_1]    = loop_dst[0];
  end

endmodule

`default_nettype wire

// ==== source/cheri_fault_latch.sv ====
// ################################################
// CHERI fault capture.
// Keeps a sticky record of faults seen and pulses
// each fault once, on its first occurrence.
// ################################################
`timescale 1ns/1ps
`default_nettype none

module cheri_fault_latch (
  input  wire                             clk_i,
  input  wire                             rst_ni,
  // Raw fault lines; these are modulated to drive LEDs.
  input  wire board_status_pkg::cheri_fault_t fault_i,
  // One-cycle mask of faults seen for the first time.
  output board_status_pkg::cheri_fault_t      fault_new_o,
  // Every fault seen since reset.
  output board_status_pkg::cheri_fault_t      fault_seen_o
);

  board_status_pkg::cheri_fault_t fault_new_d;
  board_status_pkg::cheri_fault_t fault_new_q;
  board_status_pkg::cheri_fault_t fault_seen_q;

  // Faults raised now that are not in the record yet.
  assign fault_new_d = fault_i & ~fault_seen_q;

  // The pulse and the record update on the same edge.
  // Once a bit is recorded it masks itself, so a line held high or
  // toggling never pulses again.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fault_new_q  <= '0;
      fault_seen_q <= '0;
    end else begin
      fault_new_q  <= fault_new_d;
      fault_seen_q <= fault_seen_q | fault_new_d;
    end
  end

  assign fault_new_o  = fault_new_q;
  assign fault_seen_o = fault_seen_q;

endmodule

`default_nettype wire

// ==== source/pin_loopback.sv ====
// ################################################
// Loopback retiming register.
// Breaks the loop between the output and input pin
// vectors with one clocked stage.
// ################################################
`timescale 1ns/1ps
`default_nettype none

module pin_loopback (
  input  wire                    clk_i,
  input  wire                    rst_ni,
  // Source pins, gathered by the top level.
  input  wire pin_map_pkg::loopback_t src_i,
  // Destination pins, one cycle later.
  output pin_map_pkg::loopback_t     dst_o
);

  pin_map_pkg::loopback_t loop_q;

  // Single stage.
  // Loop analysis works on whole nets, so even disjoint bits of the
  // pin vectors would look circular without this register.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      loop_q <= '0;
    end else begin
      loop_q <= src_i;
    end
  end

  assign dst_o = loop_q;

endmodule

`default_nettype wire

// ==== source/spi_line_drive.sv ====
// ################################################
// SPI routing for flash, microSD, PMOD SF3 and LCD.
// PMOD lines default high when not driven; the LCD
// data line turns around between copi and cipo.
// ################################################
`timescale 1ns/1ps
`default_nettype none

`include "board_macros.svh"

module spi_line_drive (
  input  wire pin_map_pkg::out_pins_t out_pins_i,
  // PMOD1 lines: bit 0 cs, bit 1 copi, bit 2 sck.
  input  wire  [2:0] pmod_pins_i,
  input  wire  [2:0] pmod_en_i,
  // Data returned by the devices.
  input  wire        flash_cipo_i,
  input  wire        sd_cipo_i,
  input  wire        pmod_cipo_i,
  // LCD half-duplex data.
  input  wire        lcd_copi_i,
  input  wire        lcd_copi_en_i,
  input  wire        lcd_dev_cipo_i,
  // Device side.
  output logic       flash_sck_o,
  output logic       flash_cs_o,
  output logic       flash_copi_o,
  output logic       sd_sck_o,
  output logic       sd_cs_o,
  output logic       sd_copi_o,
  output logic       pmod_sck_o,
  output logic       pmod_cs_o,
  output logic       pmod_copi_o,
  output logic       lcd_line_o,
  // System side.
  output logic       flash_cipo_o,
  output logic       sd_cipo_o,
  output logic       pmod_cipo_o
);

  // Flash on the application SPI pins.
  assign flash_sck_o  = out_pins_i[pin_map_pkg::OUT_PIN_APPSPI_CLK];
  assign flash_cs_o   = out_pins_i[pin_map_pkg::OUT_PIN_APPSPI_CS];
  assign flash_copi_o = out_pins_i[pin_map_pkg::OUT_PIN_APPSPI_D0];
  assign flash_cipo_o = flash_cipo_i;

  // microSD in SPI mode: cmd is copi, dat3 is cs.
  assign sd_sck_o  = out_pins_i[pin_map_pkg::OUT_PIN_MICROSD_CLK];
  assign sd_cs_o   = out_pins_i[pin_map_pkg::OUT_PIN_MICROSD_DAT3];
  assign sd_copi_o = out_pins_i[pin_map_pkg::OUT_PIN_MICROSD_CMD];
  assign sd_cipo_o = sd_cipo_i;

  // PMOD SF3; cs stays deasserted while the pin is released.
  assign pmod_cs_o   = pmod_en_i[0] ? pmod_pins_i[0] : `LINE_IDLE;
  assign pmod_copi_o = pmod_en_i[1] ? pmod_pins_i[1] : `LINE_IDLE;
  assign pmod_sck_o  = pmod_en_i[2] ? pmod_pins_i[2] : `LINE_IDLE;
  assign pmod_cipo_o = pmod_cipo_i;

  // One shared wire, owned by whichever end is talking.
  assign lcd_line_o = lcd_copi_en_i ? lcd_copi_i : lcd_dev_cipo_i;

endmodule

`default_nettype wire

// ==== source/i2c_bus_resolve.sv ====
// ################################################
// Open-drain resolution of the three I2C buses.
// Bit 0 is the RPi ID bus, bit 1 the RPi secondary
// bus and bit 2 the QWIIC1 bus.
// ################################################
`timescale 1ns/1ps
`default_nettype none

`include "board_macros.svh"

module i2c_bus_resolve (
  // Controller drive and enable, one bit per bus.
  input  wire  [2:0] scl_o_i,
  input  wire  [2:0] scl_oe_i,
  input  wire  [2:0] sda_o_i,
  input  wire  [2:0] sda_oe_i,
  // Pull-down from each device model.
  input  wire  [2:0] scl_dev_i,
  input  wire  [2:0] sda_dev_i,
  // Lines as the device models see them.
  output logic [2:0] scl_bus_o,
  output logic [2:0] sda_bus_o,
  // Lines fed back to the controller.
  output logic [2:0] scl_in_o,
  output logic [2:0] sda_in_o
);

  always_comb begin
    for (int b = 0; b < 3; b++) begin
      // A released line floats up to the pull-up level.
      scl_bus_o[b] = scl_oe_i[b] ? scl_o_i[b] : `LINE_IDLE;
      sda_bus_o[b] = sda_oe_i[b] ? sda_o_i[b] : `LINE_IDLE;
    end
  end

  // Wired-AND of both ends of the bus.
  // The controller sees its own bits merged with the device's, so a
  // matching transmission is not taken for contention.
  assign scl_in_o = scl_bus_o & scl_dev_i;
  assign sda_in_o = sda_bus_o & sda_dev_i;

endmodule

`default_nettype wire

// ==== source/board_status_pkg.sv ====
// ################################################
// Board status types.
// CHERI fault vector and the name of each fault bit.
// ################################################
`default_nettype none

`include "board_macros.svh"

package board_status_pkg;

  // One line per CHERI exception class.
  typedef logic [`CHERI_ERR_NUM-1:0] cheri_fault_t;

  // Bit positions within cheri_fault_t.
  typedef enum int unsigned {
    CHERI_FAULT_BOUNDS                 = 0,
    CHERI_FAULT_TAG                    = 1,
    CHERI_FAULT_SEAL                   = 2,
    CHERI_FAULT_PERMIT_EXECUTE         = 3,
    CHERI_FAULT_PERMIT_LOAD            = 4,
    CHERI_FAULT_PERMIT_STORE           = 5,
    CHERI_FAULT_PERMIT_STORE_CAP       = 6,
    // Store of a local capability.
    CHERI_FAULT_PERMIT_STORE_LOCAL_CAP = 7,
    // Access to system registers.
    CHERI_FAULT_PERMIT_ACCESS_SYS_REGS = 8
  } cheri_fault_e;

endpackage

`default_nettype wire

// ==== source/pin_map_pkg.sv ====
// ################################################
// Pin map of the board.
// Pin vector types and the index of every pin the adapter uses.
// ################################################
`default_nettype none

`include "board_macros.svh"

package pin_map_pkg;

  // Pin vectors, as seen at the pinmux boundary.
  typedef logic [`OUT_PIN_NUM-1:0]   out_pins_t;
  typedef logic [`IN_PIN_NUM-1:0]    in_pins_t;
  typedef logic [`INOUT_PIN_NUM-1:0] inout_pins_t;

  // Output-only pin indices.
  typedef enum int unsigned {
    OUT_PIN_SER0_TX      = 0,
    OUT_PIN_APPSPI_CLK   = 1,
    OUT_PIN_APPSPI_D0    = 2,
    OUT_PIN_APPSPI_CS    = 3,
    OUT_PIN_MICROSD_CMD  = 4,
    OUT_PIN_MICROSD_CLK  = 5,
    OUT_PIN_MICROSD_DAT3 = 6,
    OUT_PIN_MB10         = 7,
    OUT_PIN_MB7          = 8,
    OUT_PIN_MB4          = 9
  } out_pin_e;

  // Input-only pin indices.
  typedef enum int unsigned {
    IN_PIN_SER0_RX      = 0,
    IN_PIN_APPSPI_D1    = 1,
    IN_PIN_MICROSD_DAT0 = 2,
    IN_PIN_MB8          = 3,
    IN_PIN_MB3          = 4
  } in_pin_e;

  // Bidirectional pin indices.
  // RPi header, QWIIC1, PMOD1 SPI, Arduino header, PMOD0 and PMODC.
  typedef enum int unsigned {
    INOUT_PIN_RPH_G0     = 0,
    INOUT_PIN_RPH_G1     = 1,
    INOUT_PIN_RPH_G2_SDA = 2,
    INOUT_PIN_RPH_G3_SCL = 3,
    INOUT_PIN_SCL1       = 4,
    INOUT_PIN_SDA1       = 5,
    INOUT_PIN_PMOD1_1    = 6,
    INOUT_PIN_PMOD1_2    = 7,
    INOUT_PIN_PMOD1_3    = 8,
    INOUT_PIN_PMOD1_4    = 9,
    INOUT_PIN_AH_TMPIO0  = 10,
    INOUT_PIN_AH_TMPIO1  = 11,
    INOUT_PIN_AH_TMPIO8  = 12,
    INOUT_PIN_AH_TMPIO9  = 13,
    INOUT_PIN_PMOD0_1    = 14,
    INOUT_PIN_PMOD0_8    = 15,
    INOUT_PIN_PMOD0_10   = 16,
    INOUT_PIN_PMODC_1    = 17
  } inout_pin_e;

  // One bit per loopback pair.
  typedef logic [`LOOPBACK_NUM-1:0] loopback_t;

endpackage

`default_nettype wire

// ==== source/board_macros.svh ====
// ################################################
// Board pin adapter constants.
// Pin counts of the fixed board map, fault and loopback widths,
// and the level seen on an undriven line.
// ################################################
`ifndef BOARD_MACROS_SVH
`define BOARD_MACROS_SVH

// Output-only pins from the pinmux.
`define OUT_PIN_NUM 10

// Input-only pins read by the system.
`define IN_PIN_NUM 5

// Bidirectional pins with output enables.
`define INOUT_PIN_NUM 18

// CHERI fault lines, one per exception class.
`define CHERI_ERR_NUM 9

// Pin pairs retimed through the loopback register.
`define LOOPBACK_NUM 7

// Pull-ups on the board make an undriven line read high.
`define LINE_IDLE 1'b1

`endif
